// ==== lsu_pkg.sv ====
/*
 Shared definitions for the load/store control pipeline.
 Holds the memory map, access size and fault cause codes, and the load data
 view. Modules pull it in with a wildcard import in their header.
 */
package lsu_pkg;

   // Data path widths
   localparam int XLEN     = 32;
   localparam int OFFSET_W = 12;

   //**************************************************
   // Memory map
   //**************************************************
   localparam logic [XLEN-1:0] DCCM_BASE = 32'hF004_0000;
   localparam logic [XLEN-1:0] DCCM_SIZE = 32'h0001_0000;  // 64 KB
   localparam logic [XLEN-1:0] PIC_BASE  = 32'hF00C_0000;
   localparam logic [XLEN-1:0] PIC_SIZE  = 32'h0000_8000;  // 32 KB

   // Access size codes, code 3 is never issued
   localparam logic [1:0] SZ_BYTE = 2'd0;
   localparam logic [1:0] SZ_HALF = 2'd1;
   localparam logic [1:0] SZ_WORD = 2'd2;

   //**************************************************
   // Fault cause codes
   //**************************************************
   localparam int MSCAUSE_W = 4;

   localparam logic [MSCAUSE_W-1:0] MSCAUSE_NONE     = 4'd0;
   localparam logic [MSCAUSE_W-1:0] MSCAUSE_MISALIGN = 4'd1;
   localparam logic [MSCAUSE_W-1:0] MSCAUSE_CROSS    = 4'd2;  // Start and end in different regions
   localparam logic [MSCAUSE_W-1:0] MSCAUSE_PIC_SIZE = 4'd3;  // PIC only takes word accesses

   // Load data word, seen either as bytes or as halfwords
   typedef union packed {
      logic [3:0][7:0]  bytes;
      logic [1:0][15:0] halves;
   } ld_data_t;

endpackage

// ==== lsu_addr_if.sv ====
/*
 Address side results handed from the address path to the result stage.
 The address path drives src, the result stage reads dst.
 */
interface lsu_addr_if import lsu_pkg::*; ();

   logic [XLEN-1:0]      addr_r;          // Fault address at R
   logic                 external_m;      // Bus data capture enable
   logic                 external_r;
   logic                 misaligned_r;
   logic                 access_fault_r;
   logic [MSCAUSE_W-1:0] mscause_r;

   modport src (
      output addr_r, external_m, external_r, misaligned_r, access_fault_r, mscause_r
   );

   modport dst (
      input  addr_r, external_m, external_r, misaligned_r, access_fault_r, mscause_r
   );

endinterface

// ==== lsu_pkt_if.sv ====
/*
 R-stage control packet handed from the packet pipe to the result stage.
 The packet pipe drives src, the result stage reads dst.
 */
interface lsu_pkt_if;

   logic       valid_r;
   logic       load_r;
   logic       store_r;
   logic [1:0] size_r;    // SZ_* code
   logic       unsign_r;  // Zero extend when set

   modport src (
      output valid_r, load_r, store_r, size_r, unsign_r
   );

   modport dst (
      input  valid_r, load_r, store_r, size_r, unsign_r
   );

endinterface

// ==== lsu_addr_path.sv ====
/*
 Address side of the load/store pipe.
 Builds start and end addresses at D, decodes them against the memory map,
 derives misaligned and access faults, and carries all of it through M and R.
 */
module lsu_addr_path import lsu_pkg::*; (
   input  logic                clk,
   input  logic                reset,
   input  logic [XLEN-1:0]     rs1_d,
   input  logic [OFFSET_W-1:0] offset_d,
   input  logic [1:0]          size_d,
   output logic [XLEN-1:0]     lsu_addr_d,
   output logic [XLEN-1:0]     lsu_addr_m,
   output logic [XLEN-1:0]     lsu_addr_r,
   output logic [XLEN-1:0]     end_addr_d,
   output logic                addr_external_m,
   output logic                addr_in_dccm_r,
   output logic                addr_in_pic_r,
   lsu_addr_if.src             addr
);

   logic [XLEN-1:0]      offset_sext_d;
   logic [1:0]           len_m1_d;
   logic                 dccm_start_d, pic_start_d;
   logic                 dccm_end_d, pic_end_d;
   logic                 unaligned_d;
   logic                 misaligned_d, cross_d, pic_size_d, access_fault_d;
   logic [MSCAUSE_W-1:0] mscause_d;

   logic                 in_dccm_m, in_pic_m, external_m, external_r;
   logic                 misaligned_m, misaligned_r;
   logic                 access_fault_m, access_fault_r;
   logic [MSCAUSE_W-1:0] mscause_m, mscause_r;

   // Region hit for a power of two sized, size aligned region
   function automatic logic in_region(input logic [XLEN-1:0] a,
                                      input logic [XLEN-1:0] base,
                                      input logic [XLEN-1:0] size);
      return (a & ~(size - 1'b1)) == base;
   endfunction

   //**************************************************
   // D stage address generation
   //**************************************************
   assign offset_sext_d = {{(XLEN-OFFSET_W){offset_d[OFFSET_W-1]}}, offset_d};
   assign lsu_addr_d    = rs1_d + offset_sext_d;

   always_comb begin
      case (size_d)
         SZ_HALF: len_m1_d = 2'd1;
         SZ_WORD: len_m1_d = 2'd3;
         default: len_m1_d = 2'd0;   // Byte
      endcase
   end

   assign end_addr_d = lsu_addr_d + {{(XLEN-2){1'b0}}, len_m1_d};

   // Memory map decode of both ends
   assign dccm_start_d = in_region(lsu_addr_d, DCCM_BASE, DCCM_SIZE);
   assign pic_start_d  = in_region(lsu_addr_d, PIC_BASE, PIC_SIZE);
   assign dccm_end_d   = in_region(end_addr_d, DCCM_BASE, DCCM_SIZE);
   assign pic_end_d    = in_region(end_addr_d, PIC_BASE, PIC_SIZE);

   //**************************************************
   // Fault detection, fixed priority
   //**************************************************
   assign unaligned_d  = ((size_d == SZ_HALF) & lsu_addr_d[0]) |
                         ((size_d == SZ_WORD) & (|lsu_addr_d[1:0]));
   assign misaligned_d = unaligned_d & ~dccm_start_d;  // DCCM handles unaligned itself
   assign cross_d      = ~misaligned_d & ({dccm_start_d, pic_start_d} != {dccm_end_d, pic_end_d});
   assign pic_size_d   = ~misaligned_d & ~cross_d & pic_start_d & (size_d != SZ_WORD);
   assign access_fault_d = cross_d | pic_size_d;

   assign mscause_d = misaligned_d ? MSCAUSE_MISALIGN :
                      cross_d      ? MSCAUSE_CROSS    :
                      pic_size_d   ? MSCAUSE_PIC_SIZE : MSCAUSE_NONE;

   //**************************************************
   // M and R stage registers
   //**************************************************
   always_ff @(posedge clk) begin
      lsu_addr_m <= lsu_addr_d;
      lsu_addr_r <= lsu_addr_m;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         in_dccm_m      <= 1'b0;
         in_pic_m       <= 1'b0;
         external_m     <= 1'b0;
         misaligned_m   <= 1'b0;
         access_fault_m <= 1'b0;
         mscause_m      <= MSCAUSE_NONE;
         addr_in_dccm_r <= 1'b0;
         addr_in_pic_r  <= 1'b0;
         external_r     <= 1'b0;
         misaligned_r   <= 1'b0;
         access_fault_r <= 1'b0;
         mscause_r      <= MSCAUSE_NONE;
      end else begin
         in_dccm_m      <= dccm_start_d;
         in_pic_m       <= pic_start_d;
         external_m     <= ~dccm_start_d & ~pic_start_d;
         misaligned_m   <= misaligned_d;
         access_fault_m <= access_fault_d;
         mscause_m      <= mscause_d;
         addr_in_dccm_r <= in_dccm_m;
         addr_in_pic_r  <= in_pic_m;
         external_r     <= external_m;
         misaligned_r   <= misaligned_m;
         access_fault_r <= access_fault_m;
         mscause_r      <= mscause_m;
      end
   end

   assign addr_external_m     = external_m;
   assign addr.addr_r         = lsu_addr_r;
   assign addr.external_m     = external_m;
   assign addr.external_r     = external_r;
   assign addr.misaligned_r   = misaligned_r;
   assign addr.access_fault_r = access_fault_r;
   assign addr.mscause_r      = mscause_r;

endmodule

// ==== lsu_pkt_pipe.sv ====
/*
 Control packet pipe from D to R.
 Valid is killed by flush_m_up on entry to M and on the step from M to R,
 the remaining packet bits simply follow along.
 */
module lsu_pkt_pipe import lsu_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       valid_d,
   input  logic       load_d,
   input  logic       store_d,
   input  logic       unsign_d,
   input  logic [1:0] size_d,
   input  logic       flush_m_up,   // Kills the D and M operations
   lsu_pkt_if.src     pkt
);

   logic       valid_m, valid_r;
   logic       load_m, load_r;
   logic       store_m, store_r;
   logic       unsign_m, unsign_r;
   logic [1:0] size_m, size_r;

   //**************************************************
   // Valid bits, cleared on reset and on flush
   //**************************************************
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_m <= 1'b0;
         valid_r <= 1'b0;
      end else begin
         valid_m <= valid_d & ~flush_m_up;
         valid_r <= valid_m & ~flush_m_up;
      end
   end

   // Packet payload, qualified by valid downstream
   always_ff @(posedge clk) begin
      load_m   <= load_d;
      store_m  <= store_d;
      unsign_m <= unsign_d;
      size_m   <= size_d;

      load_r   <= load_m;
      store_r  <= store_m;
      unsign_r <= unsign_m;
      size_r   <= size_m;
   end

   // Size codes are checked against SZ_* only at R
   assign pkt.valid_r  = valid_r;
   assign pkt.load_r   = load_r;
   assign pkt.store_r  = store_r;
   assign pkt.size_r   = size_r;
   assign pkt.unsign_r = unsign_r;

endmodule

// ==== lsu_result_ctl.sv ====
/*
 R-stage result logic.
 Captures bus read data at M, picks bus or local memory data at R, formats
 it by size and sign, and builds the exception outputs and commit.
 */
module lsu_result_ctl import lsu_pkg::*; (
   input  logic                 clk,
   input  logic                 reset,
   input  logic [XLEN-1:0]      bus_read_data_m,
   input  logic [XLEN-1:0]      ld_data_r,
   input  logic                 flush_r,
   lsu_addr_if.dst              addr,
   lsu_pkt_if.dst               pkt,
   output logic [XLEN-1:0]      lsu_result_r,
   output logic                 lsu_commit_r,
   output logic                 exc_valid_r,
   output logic                 exc_type_r,
   output logic [MSCAUSE_W-1:0] mscause_r
);

   logic [XLEN-1:0] bus_data_r;
   ld_data_t        datafn_r;

   //**************************************************
   // Bus data capture
   //**************************************************
   always_ff @(posedge clk) begin
      if (addr.external_m)
         bus_data_r <= bus_read_data_m;
   end

   // Data source for the R operation
   assign datafn_r = addr.external_r ? bus_data_r : ld_data_r;

   //**************************************************
   // Load formatting
   //**************************************************
   always_comb begin
      case (pkt.size_r)
         SZ_BYTE: begin
            if (pkt.unsign_r)
               lsu_result_r = {{(XLEN-8){1'b0}}, datafn_r.bytes[0]};
            else
               lsu_result_r = {{(XLEN-8){datafn_r.bytes[0][7]}}, datafn_r.bytes[0]};
         end
         SZ_HALF: begin
            if (pkt.unsign_r)
               lsu_result_r = {{(XLEN-16){1'b0}}, datafn_r.halves[0]};
            else
               lsu_result_r = {{(XLEN-16){datafn_r.halves[0][15]}}, datafn_r.halves[0]};
         end
         default: lsu_result_r = datafn_r;   // Word passes through
      endcase
   end

   //**************************************************
   // Exceptions and commit
   //**************************************************
   assign exc_valid_r = pkt.valid_r & (addr.misaligned_r | addr.access_fault_r);
   assign exc_type_r  = addr.access_fault_r;   // 0 is misaligned
   assign mscause_r   = addr.mscause_r;

   // An exception does not hold off commit, only flush_r does
   assign lsu_commit_r = pkt.valid_r & (pkt.load_r | pkt.store_r) & ~flush_r;

endmodule

// ==== lsu_ctl_top.sv ====
/*
 Top level of the load/store control pipeline.
 Ties the address path, the packet pipe and the result stage together
 through two interfaces and brings everything out on plain ports.
 */
module lsu_ctl_top import lsu_pkg::*; (
   input  logic                 clk,
   input  logic                 reset,

   // D stage operation
   input  logic                 valid_d,
   input  logic                 load_d,
   input  logic                 store_d,
   input  logic                 unsign_d,
   input  logic [1:0]           size_d,
   input  logic [XLEN-1:0]      rs1_d,
   input  logic [OFFSET_W-1:0]  offset_d,

   input  logic                 flush_m_up,
   input  logic                 flush_r,
   input  logic [XLEN-1:0]      bus_read_data_m,
   input  logic [XLEN-1:0]      ld_data_r,

   // Addresses down the pipe
   output logic [XLEN-1:0]      lsu_addr_d,
   output logic [XLEN-1:0]      lsu_addr_m,
   output logic [XLEN-1:0]      lsu_addr_r,
   output logic [XLEN-1:0]      end_addr_d,
   output logic                 addr_external_m,
   output logic                 addr_in_dccm_r,
   output logic                 addr_in_pic_r,

   // R stage results
   output logic [XLEN-1:0]      lsu_result_r,
   output logic                 lsu_commit_r,
   output logic                 exc_valid_r,
   output logic                 exc_type_r,
   output logic [MSCAUSE_W-1:0] mscause_r
);

   lsu_addr_if addr_bus ();
   lsu_pkt_if  pkt_bus ();

   lsu_addr_path u_addr_path (
      .clk             (clk),
      .reset           (reset),
      .rs1_d           (rs1_d),
      .offset_d        (offset_d),
      .size_d          (size_d),
      .lsu_addr_d      (lsu_addr_d),
      .lsu_addr_m      (lsu_addr_m),
      .lsu_addr_r      (lsu_addr_r),
      .end_addr_d      (end_addr_d),
      .addr_external_m (addr_external_m),
      .addr_in_dccm_r  (addr_in_dccm_r),
      .addr_in_pic_r   (addr_in_pic_r),
      .addr            (addr_bus.src)
   );

   lsu_pkt_pipe u_pkt_pipe (
      .clk        (clk),
      .reset      (reset),
      .valid_d    (valid_d),
      .load_d     (load_d),
      .store_d    (store_d),
      .unsign_d   (unsign_d),
      .size_d     (size_d),
      .flush_m_up (flush_m_up),
      .pkt        (pkt_bus.src)
   );

   lsu_result_ctl u_result_ctl (
      .clk             (clk),
      .reset           (reset),
      .bus_read_data_m (bus_read_data_m),
      .ld_data_r       (ld_data_r),
      .flush_r         (flush_r),
      .addr            (addr_bus.dst),
      .pkt             (pkt_bus.dst),
      .lsu_result_r    (lsu_result_r),
      .lsu_commit_r    (lsu_commit_r),
      .exc_valid_r     (exc_valid_r),
      .exc_type_r      (exc_type_r),
      .mscause_r       (mscause_r)
   );

endmodule

// ==== tb_lsu_ctl_assert.sv ====
/*
 Concurrent checks on the exception and commit outputs of the result stage.
 Bound into every lsu_result_ctl instance.
 */
module tb_lsu_ctl_assert import lsu_pkg::*; (
   input logic                 clk,
   input logic                 reset,
   input logic                 valid_r,
   input logic                 flush_r,
   input logic [XLEN-1:0]      addr_r,
   input logic                 lsu_commit_r,
   input logic                 exc_valid_r,
   input logic                 exc_type_r,
   input logic [MSCAUSE_W-1:0] mscause_r
);

   int fail_count = 0;

   // An exception needs a live operation
   exc_needs_valid: assert property (
      @(posedge clk) disable iff (reset) exc_valid_r |-> valid_r
   ) else begin
      fail_count++;
      $error("exc_valid_r is set without valid_r");
   end

   no_commit_on_flush: assert property (
      @(posedge clk) disable iff (reset) flush_r |-> !lsu_commit_r
   ) else begin
      fail_count++;
      $error("lsu_commit_r is set while flush_r is high");
   end

   exc_has_cause: assert property (
      @(posedge clk) disable iff (reset) exc_valid_r |-> (mscause_r != MSCAUSE_NONE)
   ) else begin
      fail_count++;
      $error("exc_valid_r is set with a zero cause");
   end

   // A misaligned fault always points at an unaligned address
   misalign_addr_unaligned: assert property (
      @(posedge clk) disable iff (reset)
         (exc_valid_r && !exc_type_r) |-> (addr_r[1:0] != 2'b00)
   ) else begin
      fail_count++;
      $error("misaligned fault reported at an aligned address");
   end

endmodule

bind lsu_result_ctl tb_lsu_ctl_assert result_ctl_checks (
   .clk          (clk),
   .reset        (reset),
   .valid_r      (pkt.valid_r),
   .flush_r      (flush_r),
   .addr_r       (addr.addr_r),
   .lsu_commit_r (lsu_commit_r),
   .exc_valid_r  (exc_valid_r),
   .exc_type_r   (exc_type_r),
   .mscause_r    (mscause_r)
);

// ==== tb_lsu_ctl.sv ====
/*
 Testbench for the load/store control pipeline.
 Reads one operation per line from lsu_input.txt and issues the operations
 back to back at D. Addresses are checked at D and M, results at R.
 */
module tb_lsu_ctl import lsu_pkg::*; ();

   localparam int CLK_PERIOD = 40;
   localparam int MAX_OPS    = 64;
   localparam int REC_W      = 248;   // 62 hex digits per line

   logic                 clk = 1'b0;
   logic                 reset;
   logic                 valid_d, load_d, store_d, unsign_d;
   logic [1:0]           size_d;
   logic [XLEN-1:0]      rs1_d;
   logic [OFFSET_W-1:0]  offset_d;
   logic                 flush_m_up, flush_r;
   logic [XLEN-1:0]      bus_read_data_m, ld_data_r;
   logic [XLEN-1:0]      lsu_addr_d, lsu_addr_m, lsu_addr_r, end_addr_d;
   logic                 addr_external_m, addr_in_dccm_r, addr_in_pic_r;
   logic [XLEN-1:0]      lsu_result_r;
   logic                 lsu_commit_r, exc_valid_r, exc_type_r;
   logic [MSCAUSE_W-1:0] mscause_r;

   logic [REC_W-1:0]     ops [MAX_OPS];
   int                   n_ops;
   int                   cycle_count = 0;
   int                   cycle_limit = 1000;
   logic [31:0]          lfsr_state;

   lsu_ctl_top DUT (.*);

   always #(CLK_PERIOD/2) clk = ~clk;

   //**************************************************
   // Failure handling and compare tasks
   //**************************************************
   task automatic abort_run();
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input logic [XLEN-1:0] actual,
                             input logic [XLEN-1:0] expected);
      if (actual !== expected) begin
         $display("** Error at time %0t: %s is %h, expected %h", $time, name, actual, expected);
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         $display("** Error at time %0t: %s is %b, expected %b", $time, name, actual, expected);
         abort_run();
      end
   endtask

   task automatic check_cause(input string name, input logic [MSCAUSE_W-1:0] actual,
                              input logic [MSCAUSE_W-1:0] expected);
      if (actual !== expected) begin
         $display("** Error at time %0t: %s is %h, expected %h", $time, name, actual, expected);
         abort_run();
      end
   endtask

   // Galois LFSR, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [XLEN-1:0] random_word();
      logic [XLEN-1:0] w;
      w = '0;
      for (int i = 0; i < XLEN; i++) begin
         w = {w[XLEN-2:0], lfsr_state[0]};   // One step per bit
         lfsr_state = lfsr_step(lfsr_state);
      end
      return w;
   endfunction

   // Region hits by range compare
   function automatic logic in_dccm(input logic [XLEN-1:0] a);
      return (a >= DCCM_BASE) && (a < DCCM_BASE + DCCM_SIZE);
   endfunction

   function automatic logic in_pic(input logic [XLEN-1:0] a);
      return (a >= PIC_BASE) && (a < PIC_BASE + PIC_SIZE);
   endfunction

   // Neither DCCM nor PIC means the bus
   function automatic logic is_external(input logic [XLEN-1:0] a);
      return !(in_dccm(a) || in_pic(a));
   endfunction

   task automatic load_ops();
      for (int i = 0; i < MAX_OPS; i++)
         ops[i] = {4'hf, {(REC_W-36){1'b0}}, i};   // Top nibble f marks an empty slot
      $readmemh("lsu_input.txt", ops);
      n_ops = 0;
      while (n_ops < MAX_OPS && ops[n_ops][247:244] != 4'hf)
         n_ops++;
      if (n_ops == 0) begin
         $display("No operations were found in lsu_input.txt");
         abort_run();
      end
   endtask

   //**************************************************
   // Per cycle drive and check
   //**************************************************
   task automatic drive_cycle(input int k);
      logic [REC_W-1:0] rec;
      if (k < n_ops) begin
         rec      = ops[k];
         valid_d  = rec[244];
         load_d   = rec[240];
         store_d  = rec[236];
         size_d   = rec[233:232];
         unsign_d = rec[228];
         rs1_d    = rec[227:196];
         offset_d = rec[195:184];
      end else begin
         valid_d  = 1'b0;
         load_d   = 1'b0;
         store_d  = 1'b0;
         size_d   = SZ_BYTE;
         unsign_d = 1'b0;
         rs1_d    = '0;
         offset_d = '0;
      end
      flush_m_up      = 1'b0;
      bus_read_data_m = random_word();
      if (k >= 1 && k - 1 < n_ops) begin      // Operation now at M
         rec        = ops[k-1];
         flush_m_up = rec[180];
         if (is_external(rec[111:80]))
            bus_read_data_m = rec[143:112];
      end
      flush_r   = 1'b0;
      ld_data_r = '0;
      if (k >= 2 && k - 2 < n_ops) begin      // Operation now at R
         rec       = ops[k-2];
         flush_r   = rec[176];
         ld_data_r = rec[175:144];
      end
   endtask

   task automatic check_cycle(input int k);
      logic [REC_W-1:0] rec;
      if (k < n_ops) begin
         rec = ops[k];
         check_word("lsu_addr_d", lsu_addr_d, rec[111:80]);
         check_word("end_addr_d", end_addr_d, rec[79:48]);
      end
      if (k >= 1 && k - 1 < n_ops) begin
         rec = ops[k-1];
         check_word("lsu_addr_m", lsu_addr_m, rec[111:80]);
         check_bit("addr_external_m", addr_external_m, is_external(rec[111:80]));
      end
      if (k >= 2) begin
         rec = ops[k-2];
         check_word("lsu_addr_r", lsu_addr_r, rec[111:80]);
         check_bit("addr_in_dccm_r", addr_in_dccm_r, in_dccm(rec[111:80]));
         check_bit("addr_in_pic_r", addr_in_pic_r, in_pic(rec[111:80]));
         check_word("lsu_result_r", lsu_result_r, rec[47:16]);
         check_bit("lsu_commit_r", lsu_commit_r, rec[12]);
         check_bit("exc_valid_r", exc_valid_r, rec[8]);
         check_bit("exc_type_r", exc_type_r, rec[4]);
         check_cause("mscause_r", mscause_r, rec[3:0]);
      end else begin
         check_bit("lsu_commit_r", lsu_commit_r, 1'b0);   // Pipe still empty after reset
         check_bit("exc_valid_r", exc_valid_r, 1'b0);
      end
      if (DUT.u_result_ctl.result_ctl_checks.fail_count != 0) begin
         $display("A concurrent assertion on the result stage failed");
         abort_run();
      end
   endtask

   // Run limit from the number of operations
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("The run did not finish within %0d cycles", cycle_limit);
         abort_run();
      end
   end

   initial begin
      reset      = 1'b1;
      lfsr_state = 32'hedaa_a9d1;
      drive_cycle(MAX_OPS + 2);   // Idle values on every input
      load_ops();
      cycle_limit = 3 * n_ops + 20;

      repeat (4) begin
         @(negedge clk);
         #(CLK_PERIOD/4);
         check_bit("lsu_commit_r", lsu_commit_r, 1'b0);
         check_bit("exc_valid_r", exc_valid_r, 1'b0);
      end
      @(negedge clk);
      reset = 1'b0;

      for (int k = 0; k < n_ops + 2; k++) begin
         if (k > 0)
            @(negedge clk);
         drive_cycle(k);
         #(CLK_PERIOD/4);
         check_cycle(k);
      end

      if (DUT.u_result_ctl.result_ctl_checks.fail_count == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// ==== lsu_input.txt ====
// valid_load_store_size_unsign_rs1_offset_killm_flushr_lddata_busdata, then expected
// lsuaddrd_endaddrd_result_commit_excvalid_exctype_mscause, all fields in hex
1_1_0_2_0_f0040100_004_0_0_87654321_00000000_f0040104_f0040107_87654321_1_0_0_0
1_1_0_0_0_f0040200_fff_0_0_00000080_00000000_f00401ff_f00401ff_ffffff80_1_0_0_0
1_1_0_0_1_f0041000_800_0_0_123456f0_00000000_f0040800_f0040800_000000f0_1_0_0_0
1_1_0_1_0_f0040300_002_0_0_abcd9876_00000000_f0040302_f0040303_ffff9876_1_0_0_0
1_1_0_1_1_f0040400_7fe_0_0_55558001_00000000_f0040bfe_f0040bff_00008001_1_0_0_0
1_1_0_2_0_20000000_010_0_0_00000000_cafef00d_20000010_20000013_cafef00d_1_0_0_0
1_1_0_0_0_20000100_ffc_0_0_00000000_112233a5_200000fc_200000fc_ffffffa5_1_0_0_0
1_1_0_1_1_20000200_006_0_0_00000000_0badc0de_20000206_20000207_0000c0de_1_0_0_0
1_1_0_1_0_20000300_00a_0_0_00000000_12348000_2000030a_2000030b_ffff8000_1_0_0_0
1_1_0_1_0_20000400_003_0_0_00000000_89abcdef_20000403_20000404_ffffcdef_1_1_0_1
1_1_0_2_0_f004fff0_00e_0_0_deadbeef_00000000_f004fffe_f0050001_deadbeef_1_1_1_2
1_0_1_0_0_f00c0000_010_0_0_00000000_00000000_f00c0010_f00c0010_00000000_1_1_1_3
1_0_1_2_0_f00c0100_004_0_0_00000000_00000000_f00c0104_f00c0107_00000000_1_0_0_0
1_1_0_2_0_f0040500_000_1_0_11111111_00000000_f0040500_f0040503_11111111_0_0_0_0
1_1_0_2_0_30000000_001_0_0_00000000_77770000_30000001_30000004_77770000_0_0_0_1
1_1_0_1_0_f00c0200_002_0_1_00009abc_00000000_f00c0202_f00c0203_ffff9abc_0_1_1_3
1_0_1_2_0_f0040700_f00_0_0_00000000_00000000_f0040600_f0040603_00000000_1_0_0_0
0_1_0_0_1_00001000_0ff_0_0_00000000_000000ff_000010ff_000010ff_000000ff_0_0_0_0

// ==== build.f ====
lsu_pkg.sv
lsu_addr_if.sv
lsu_pkt_if.sv
lsu_addr_path.sv
lsu_pkt_pipe.sv
lsu_result_ctl.sv
lsu_ctl_top.sv
tb_lsu_ctl_assert.sv
tb_lsu_ctl.sv

// ==== Makefile ====
# Verilator build and run for the load/store control pipeline testbench

TOP = tb_lsu_ctl

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir

# Pass only when the pass message shows up in the simulation output
run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee /dev/stderr | grep -q "Everything OK"

clean:
	rm -rf obj_dir
